// File: flist.f
hdl/gf_pkg.sv
hdl/wb_pkg.sv
hdl/sbox_power13.sv
hdl/sbox_lane.sv
hdl/round_loader.sv
hdl/round_collector.sv
hdl/wb_regs.sv
hdl/spn_core_top.sv
tests/spn_assertions.sv
tests/spn_tb.sv

// File: hdl/gf_pkg.sv
package gf_pkg;

  // one field element of GF(2^6).
  localparam int sym_w = 6;

  // the transpose needs a square bit matrix.
  localparam int num_lanes = 6;

  localparam int block_w = num_lanes * sym_w;

  // up to 15 rounds.
  localparam int round_cnt_w = 4;

  // rotation amount of the round key.
  localparam int rot_w = $clog2(block_w);

  // engine sequencing.
  typedef enum logic [2:0] {
    st_idle,
    st_mix,   // mixed word in the lanes.
    st_sub,   // lanes return S.
    st_perm,  // transposed word held, pick next step.
    st_done
  } eng_state_e;

endpackage

// File: hdl/round_collector.sv
`timescale 1ns/1ps

module round_collector import gf_pkg::*; (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            clear,
  input  logic                            start,
  input  logic [block_w-1:0]              key,
  input  logic [round_cnt_w-1:0]          rounds,
  input  logic [num_lanes-1:0][sym_w-1:0] lane_out,
  input  logic [num_lanes-1:0]            out_vld,
  output logic [block_w-1:0]              state,
  output logic                            busy,
  output logic                            done,
  output logic [round_cnt_w-1:0]          round_idx,
  output logic                            next_round
);

  eng_state_e                      st;
  logic [round_cnt_w-1:0]          last_idx;
  logic                            last_q;    // stored word was the final round.
  logic                            last;
  logic [num_lanes-1:0][sym_w-1:0] xposed;

  // bit i of lane j goes to bit j of lane i.
  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      for (int j = 0; j < sym_w; j++) begin
        xposed[i][j] = lane_out[j][i];
      end
    end
  end

  assign last       = (round_idx == last_idx);
  assign busy       = (st == st_mix) || (st == st_sub) || (st == st_perm);
  assign done       = (st == st_done);
  assign next_round = (st == st_perm) && !last_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      st        <= st_idle;
      round_idx <= '0;
      last_idx  <= '0;
      last_q    <= 1'b0;
      state     <= '0;
    end else if (clear) begin
      st        <= st_idle;
      round_idx <= '0;
      last_q    <= 1'b0;
      state     <= '0;
    end else begin
      case (st)
        st_idle, st_done: begin
          if (start) begin
            st        <= st_mix;
            round_idx <= '0;
            last_idx  <= (rounds == '0) ? '0 : rounds - 1'b1; // zero runs once.
          end
        end
        st_mix: st <= st_sub;
        st_sub: begin
          if (&out_vld) begin
            state  <= last ? (xposed ^ key) : xposed; // whiten after the final round.
            last_q <= last;
            if (!last) round_idx <= round_idx + 1'b1;
            st     <= st_perm;
          end
        end
        st_perm: st <= last_q ? st_done : st_mix;
        default: st <= st_idle;
      endcase
    end
  end

endmodule

// File: hdl/round_loader.sv
`timescale 1ns/1ps

module round_loader import gf_pkg::*; (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              start,
  input  logic                              clear,
  input  logic [block_w-1:0]                pt,
  input  logic [block_w-1:0]                key,
  input  logic [block_w-1:0]                state,
  input  logic [round_cnt_w-1:0]            round_idx,
  input  logic                              next_round,
  output logic [num_lanes-1:0][sym_w-1:0]   lane_in,
  output logic                              lane_vld
);

  logic [round_cnt_w-1:0] idx;
  logic [rot_w-1:0]       rot;
  logic [2*block_w-1:0]   dbl;
  logic [block_w-1:0]     rk;
  logic [block_w-1:0]     mixed;

  // round 0 on start, the collector has not cleared its counter yet.
  assign idx = start ? '0 : round_idx;

  // six bits per round, wraps every num_lanes rounds.
  assign rot = rot_w'(sym_w * (idx % num_lanes));

  always_comb begin
    dbl   = {key, key} << rot;
    rk    = dbl[2*block_w-1:block_w]; // rotate left.
    mixed = (start ? pt : state) ^ rk;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lane_vld <= 1'b0;
    end else if (clear) begin
      lane_vld <= 1'b0;
    end else begin
      lane_vld <= start | next_round;
    end
  end

  always_ff @(posedge clk) begin
    if (start | next_round) lane_in <= mixed;
  end

endmodule

// File: hdl/sbox_lane.sv
`timescale 1ns/1ps

module sbox_lane import gf_pkg::*; (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [sym_w-1:0] in_sym,
  input  logic             in_vld,
  output logic [sym_w-1:0] out_sym,
  output logic             out_vld
);

  logic [sym_w-1:0] s_val;

  sbox_power13 u_sbox (
    .x (in_sym),
    .y (s_val)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) out_vld <= 1'b0;
    else         out_vld <= in_vld;
  end

  always_ff @(posedge clk) begin
    if (in_vld) out_sym <= s_val;
  end

endmodule

// File: hdl/sbox_power13.sv
`timescale 1ns/1ps

// y = x^13 in GF(2^6), evaluated over the GF(4) tower.
module sbox_power13 import gf_pkg::*; (
  input  logic [sym_w-1:0] x,
  output logic [sym_w-1:0] y
);

  function automatic logic [1:0] gf4_sq(input logic [1:0] a);
    return {a[0], a[1]}; // frobenius is a bit swap.
  endfunction

  function automatic logic [1:0] gf4_mul(input logic [1:0] a, input logic [1:0] b);
    logic t;
    t = (a[0] & b[1]) ^ (a[1] & b[0]);
    return {(a[0] & b[0]) ^ t, (a[1] & b[1]) ^ t};
  endfunction

  // a^3 * b, a^3 is 1 for any nonzero a.
  function automatic logic [1:0] gf4_scale(input logic [1:0] a, input logic [1:0] b);
    return b & {2{a[0] | a[1]}};
  endfunction

  logic [sym_w-1:0] w;
  logic [sym_w-1:0] p;
  logic [1:0] x0, x1, x2;
  logic [1:0] y0, y1, y2;
  logic [1:0] x3, x4, x5, x6, x7, x8;
  logic [1:0] x9, x10, x11, x12, x13, x14;

  // into the composite field.
  assign w[0] = x[0] ^ x[2] ^ x[3];
  assign w[1] = x[0] ^ x[1] ^ x[5];
  assign w[2] = x[0] ^ x[1] ^ x[2];
  assign w[3] = x[0] ^ x[2] ^ x[4] ^ x[5];
  assign w[4] = x[0] ^ x[4] ^ x[5];
  assign w[5] = x[0] ^ x[2] ^ x[5];

  assign x0 = w[1:0];
  assign x1 = w[3:2];
  assign x2 = w[5:4];

  always_comb begin
    y0  = gf4_sq(x0);
    y1  = gf4_sq(x1);
    y2  = gf4_sq(x2);
    x3  = gf4_scale(x0, x1);
    x4  = gf4_scale(x0, x2);
    x5  = gf4_scale(x1, x0);
    x6  = gf4_scale(x1, x2);
    x7  = gf4_scale(x2, x0);
    x8  = gf4_scale(x2, x1);
    x9  = gf4_mul(y0, y1);
    x10 = gf4_mul(y0, y2);
    x11 = gf4_mul(y1, y2);
    x12 = gf4_mul(y0, gf4_mul(x1, x2));
    x13 = gf4_mul(y1, gf4_mul(x0, x2));
    x14 = gf4_mul(y2, gf4_mul(x0, x1));
  end

  // fixed sum network, one per output digit.
  assign p[1:0] = x0 ^ x1 ^ x5 ^ x6 ^ x7 ^ x9 ^ x10 ^ x12 ^ x14;
  assign p[3:2] = x1 ^ x2 ^ x3 ^ x7 ^ x8 ^ x9 ^ x11 ^ x12 ^ x13;
  assign p[5:4] = x0 ^ x2 ^ x3 ^ x4 ^ x6 ^ x10 ^ x11 ^ x13 ^ x14;

  // back to polynomial basis.
  assign y[0] = p[3] ^ p[5];
  assign y[1] = p[1] ^ p[4] ^ p[5];
  assign y[2] = p[0] ^ p[4];
  assign y[3] = p[0] ^ p[2] ^ p[3] ^ p[5];
  assign y[4] = p[0] ^ p[1] ^ p[2];
  assign y[5] = p[0] ^ p[3] ^ p[5];

endmodule

// File: hdl/spn_core_top.sv
`timescale 1ns/1ps

module spn_core_top import gf_pkg::*; import wb_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 cyc,
  input  logic                 stb,
  input  logic                 we,
  input  logic [wb_addr_w-1:0] adr,
  input  logic [wb_data_w-1:0] dat_w,
  output logic [wb_data_w-1:0] dat_r,
  output logic                 ack
);

  logic                            start;
  logic                            clear;
  logic [block_w-1:0]              pt;
  logic [block_w-1:0]              key;
  logic [round_cnt_w-1:0]          rounds;
  logic [block_w-1:0]              state;
  logic                            busy;
  logic                            done;
  logic [round_cnt_w-1:0]          round_idx;
  logic                            next_round;
  logic [num_lanes-1:0][sym_w-1:0] lane_in;
  logic                            lane_vld;
  logic [num_lanes-1:0][sym_w-1:0] lane_out;
  logic [num_lanes-1:0]            out_vld;

  wb_regs u_regs (
    .clk, .arst_n, .cyc, .stb, .we, .adr, .dat_w,
    .state, .busy, .done,
    .dat_r, .ack, .start, .clear, .pt, .key, .rounds
  );

  round_loader u_loader (
    .clk, .arst_n, .start, .clear, .pt, .key, .state,
    .round_idx, .next_round,
    .lane_in, .lane_vld
  );

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    sbox_lane u_lane (
      .clk     (clk),
      .arst_n  (arst_n),
      .in_sym  (lane_in[i]),
      .in_vld  (lane_vld),
      .out_sym (lane_out[i]),
      .out_vld (out_vld[i])
    );
  end

  round_collector u_collector (
    .clk, .arst_n, .clear, .start, .key, .rounds,
    .lane_out, .out_vld,
    .state, .busy, .done, .round_idx, .next_round
  );

endmodule

// File: hdl/wb_pkg.sv
package wb_pkg;

  localparam int wb_addr_w = 3;
  localparam int wb_data_w = 32;

  // register map, word addresses.
  localparam logic [wb_addr_w-1:0] reg_ctrl   = 3'd0;
  localparam logic [wb_addr_w-1:0] reg_status = 3'd1;
  localparam logic [wb_addr_w-1:0] reg_pt_lo  = 3'd2;
  localparam logic [wb_addr_w-1:0] reg_pt_hi  = 3'd3;
  localparam logic [wb_addr_w-1:0] reg_key_lo = 3'd4;
  localparam logic [wb_addr_w-1:0] reg_key_hi = 3'd5;
  localparam logic [wb_addr_w-1:0] reg_ct_lo  = 3'd6;
  localparam logic [wb_addr_w-1:0] reg_ct_hi  = 3'd7;

  // three lanes per lo/hi register.
  localparam int half_w = 18;

  // round count field in ctrl.
  localparam int ctrl_rnd_lsb = 4;

  // ctrl bits 1:0.
  typedef enum logic [1:0] {
    cmd_none  = 2'd0,
    cmd_start = 2'd1,
    cmd_clear = 2'd2
  } cmd_op_e;

endpackage

// File: hdl/wb_regs.sv
`timescale 1ns/1ps

module wb_regs import gf_pkg::*; import wb_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   cyc,
  input  logic                   stb,
  input  logic                   we,
  input  logic [wb_addr_w-1:0]   adr,
  input  logic [wb_data_w-1:0]   dat_w,
  input  logic [block_w-1:0]     state,
  input  logic                   busy,
  input  logic                   done,
  output logic [wb_data_w-1:0]   dat_r,
  output logic                   ack,
  output logic                   start,
  output logic                   clear,
  output logic [block_w-1:0]     pt,
  output logic [block_w-1:0]     key,
  output logic [round_cnt_w-1:0] rounds
);

  logic                 req;
  logic                 wr;
  cmd_op_e              op;
  logic [wb_data_w-1:0] rd_mux;

  assign req = cyc & stb & ~ack; // new access, no wait states.
  assign wr  = req & we;
  assign op  = cmd_op_e'(dat_w[1:0]);

  always_comb begin
    rd_mux = '0;
    case (adr)
      reg_ctrl:   rd_mux[ctrl_rnd_lsb +: round_cnt_w] = rounds;
      reg_status: rd_mux[1:0] = {done, busy};
      reg_pt_lo:  rd_mux[half_w-1:0] = pt[half_w-1:0];
      reg_pt_hi:  rd_mux[half_w-1:0] = pt[block_w-1:half_w];
      reg_key_lo: rd_mux[half_w-1:0] = key[half_w-1:0];
      reg_key_hi: rd_mux[half_w-1:0] = key[block_w-1:half_w];
      reg_ct_lo:  rd_mux[half_w-1:0] = state[half_w-1:0];
      reg_ct_hi:  rd_mux[half_w-1:0] = state[block_w-1:half_w];
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack    <= 1'b0;
      start  <= 1'b0;
      clear  <= 1'b0;
      pt     <= '0;
      key    <= '0;
      rounds <= '0;
    end else begin
      ack   <= req;
      start <= 1'b0;
      clear <= 1'b0;
      if (wr) begin
        case (adr)
          reg_ctrl: begin
            rounds <= dat_w[ctrl_rnd_lsb +: round_cnt_w];
            case (op)
              cmd_start: start <= ~busy; // dropped while a block runs.
              cmd_clear: clear <= 1'b1;
              default:   ;
            endcase
          end
          reg_pt_lo:  pt[half_w-1:0]        <= dat_w[half_w-1:0];
          reg_pt_hi:  pt[block_w-1:half_w]  <= dat_w[half_w-1:0];
          reg_key_lo: key[half_w-1:0]       <= dat_w[half_w-1:0];
          reg_key_hi: key[block_w-1:half_w] <= dat_w[half_w-1:0];
          default:    ; // status and result are read only.
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) dat_r <= rd_mux;
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the SPN engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module spn_tb \
  -f flist.f \
  -o spn_sim

./obj_dir/spn_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '^>>> PASS$' sim.log; then
  exit 0
fi
exit 1

// File: tests/spn_assertions.sv
`timescale 1ns/1ps

module spn_assertions (
  input logic clk,
  input logic arst_n,
  input logic cyc,
  input logic stb,
  input logic ack,
  input logic start,
  input logic busy,
  input logic done
);

  // ack answers a request seen on the previous edge.
  ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
    ack |-> $past(cyc && stb))
    else $error("ack without a preceding cyc and stb");

  ack_single: assert property (@(posedge clk) disable iff (!arst_n)
    ack |=> !ack)
    else $error("ack held high for two cycles");

  // a granted start moves the engine out of idle or done.
  start_runs: assert property (@(posedge clk) disable iff (!arst_n)
    start |=> busy && !done)
    else $error("start did not put the engine into its run");

  start_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
    start |-> !busy)
    else $error("start issued while busy");

endmodule

bind spn_core_top spn_assertions u_assert (
  .clk    (clk),
  .arst_n (arst_n),
  .cyc    (cyc),
  .stb    (stb),
  .ack    (ack),
  .start  (start),
  .busy   (busy),
  .done   (done)
);

// File: tests/spn_tb.sv
`timescale 1ns/1ps

module spn_tb import gf_pkg::*; import wb_pkg::*;;

  logic                 clk;
  logic                 arst_n;
  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic [wb_addr_w-1:0] adr;
  logic [wb_data_w-1:0] dat_w;
  logic [wb_data_w-1:0] dat_r;
  logic                 ack;
  int                   errors;
  int                   timeouts;
  logic [15:0]          lfsr;

  spn_core_top dut0 (.clk, .arst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack);

  always #2 clk = ~clk;

  // isomorphism rows as stated in the S-box.
  localparam logic [5:0] fwd_rows [6] = '{6'b001101, 6'b100011, 6'b000111,
                                          6'b110101, 6'b110001, 6'b100101};
  localparam logic [5:0] inv_rows [6] = '{6'b101000, 6'b110010, 6'b010001,
                                          6'b101101, 6'b000111, 6'b101001};

  function automatic logic [5:0] lin_map(input logic [5:0] rows [6], input logic [5:0] v);
    logic [5:0] r;
    for (int i = 0; i < 6; i++) r[i] = ^(rows[i] & v);
    return r;
  endfunction

  // GF(4) normal basis with omega in bit 0 and omega squared in bit 1.
  function automatic logic [1:0] f4_mul(input logic [1:0] a, input logic [1:0] b);
    int e;
    if (a == 2'b00 || b == 2'b00) return 2'b00;
    e = ((a == 2'b11) ? 0 : int'(a)) + ((b == 2'b11) ? 0 : int'(b)); // sum of logs.
    case (e % 3)
      1:       return 2'b01;
      2:       return 2'b10;
      default: return 2'b11;
    endcase
  endfunction

  // normal basis e0, e0^4, e0^16 over GF(4).
  function automatic logic [5:0] cf_mul(input logic [5:0] a, input logic [5:0] b);
    logic [1:0] a0, a1, a2, b0, b1, b2, c0, c1, c2;
    logic [1:0] p01, p02, p12;
    {a2, a1, a0} = a;
    {b2, b1, b0} = b;
    p01 = f4_mul(a0, b1) ^ f4_mul(a1, b0);
    p02 = f4_mul(a0, b2) ^ f4_mul(a2, b0);
    p12 = f4_mul(a1, b2) ^ f4_mul(a2, b1);
    c0 = f4_mul(a1, b1) ^ p12 ^ p02;
    c1 = f4_mul(a2, b2) ^ p01 ^ p02;
    c2 = f4_mul(a0, b0) ^ p01 ^ p12;
    return {c2, c1, c0};
  endfunction

  function automatic logic [5:0] sbox_ref(input logic [5:0] v);
    logic [5:0] x, x2, x4, x8;
    x  = lin_map(fwd_rows, v);
    x2 = cf_mul(x, x);
    x4 = cf_mul(x2, x2);
    x8 = cf_mul(x4, x4);
    return lin_map(inv_rows, cf_mul(cf_mul(x8, x4), x));
  endfunction

  function automatic logic [35:0] cipher_ref(input logic [35:0] pt, input logic [35:0] key,
                                             input int rounds);
    logic [35:0] s, t, rk;
    int n, r6;
    n = (rounds == 0) ? 1 : rounds;
    s = pt;
    for (int r = 0; r < n; r++) begin
      r6 = 6 * (r % 6);
      rk = (r6 == 0) ? key : ((key << r6) | (key >> (36 - r6)));
      s  = s ^ rk;
      for (int j = 0; j < 6; j++) s[6*j +: 6] = sbox_ref(s[6*j +: 6]);
      for (int i = 0; i < 6; i++)
        for (int j = 0; j < 6; j++) t[6*i + j] = s[6*j + i]; // bit i of lane j.
      s = t;
    end
    return s ^ key;
  endfunction

  function automatic logic [35:0] next_rand(input int n);
    logic [35:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1); // galois step.
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  task automatic bus_access(input logic w, input logic [2:0] a, input logic [31:0] d,
                            output logic [31:0] q);
    int n;
    @(posedge clk);
    #1;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = w;
    adr   = a;
    dat_w = d;
    n = 0;
    q = '0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!ack && n < 10);
    if (!ack) begin
      $display("bus access to address %0d got no ack", a);
      timeouts++;
    end
    q   = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic bus_write(input logic [2:0] a, input logic [31:0] d);
    logic [31:0] q;
    bus_access(1'b1, a, d, q);
  endtask

  task automatic bus_read(input logic [2:0] a, output logic [31:0] q);
    bus_access(1'b0, a, '0, q);
  endtask

  task automatic check_val(input string name, input logic [35:0] exp, input logic [35:0] act);
    if (exp !== act) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic wait_done();
    logic [31:0] q;
    int n;
    n = 0;
    do begin
      bus_read(reg_status, q);
      n++;
    end while (!q[1] && n < 200);
    if (!q[1]) begin
      $display("engine did not report done in time");
      timeouts++;
    end
  endtask

  task automatic load_block(input logic [35:0] pt, input logic [35:0] key);
    bus_write(reg_pt_lo, 32'(pt[17:0]));
    bus_write(reg_pt_hi, 32'(pt[35:18]));
    bus_write(reg_key_lo, 32'(key[17:0]));
    bus_write(reg_key_hi, 32'(key[35:18]));
  endtask

  task automatic read_result(output logic [35:0] ct);
    logic [31:0] lo, hi;
    bus_read(reg_ct_lo, lo);
    bus_read(reg_ct_hi, hi);
    ct = {hi[17:0], lo[17:0]};
  endtask

  initial begin
    logic [35:0] pt, key, rv, ct;
    logic [31:0] q;
    logic [63:0] seen;
    logic [5:0]  s;
    int          rounds;
    clk      = 1'b0;
    arst_n   = 1'b0;
    cyc      = 1'b0;
    stb      = 1'b0;
    we       = 1'b0;
    adr      = '0;
    dat_w    = '0;
    errors   = 0;
    timeouts = 0;
    lfsr     = 16'd29;
    seen     = '0;
    repeat (8) @(posedge clk);
    #1 arst_n = 1'b1;

    bus_read(reg_status, q);
    check_val("reset status", 36'd0, 36'(q));

    // S sweep through lane 0 with key 0 and one round.
    for (int v = 0; v < 64; v++) begin
      load_block(36'(v), 36'd0);
      bus_write(reg_ctrl, (32'd1 << ctrl_rnd_lsb) | 32'(cmd_start));
      wait_done();
      read_result(ct);
      for (int i = 0; i < 6; i++) s[i] = ct[6*i]; // bit 0 of each lane.
      check_val("sbox sweep", 36'(sbox_ref(6'(v))), 36'(s));
      check_val("sweep block", cipher_ref(36'(v), 36'd0, 1), ct);
      if (seen[s]) begin
        $display("sbox output %0d repeats in the sweep", s);
        errors++;
      end
      seen[s] = 1'b1;
      if (v == 0) check_val("sbox zero", 36'd0, 36'(s));
    end

    for (int k = 0; k < 10; k++) begin
      pt  = next_rand(36);
      key = next_rand(36);
      rv  = next_rand(4);
      rounds = (rv[3:0] == 0) ? 1 : int'(rv[3:0]);
      load_block(pt, key);
      bus_write(reg_ctrl, (32'(rounds) << ctrl_rnd_lsb) | 32'(cmd_start));
      wait_done();
      read_result(ct);
      check_val("random block", cipher_ref(pt, key, rounds), ct);
    end

    // second start lands while the first block runs.
    pt = 36'h5a5a5a5a5;
    key = 36'h123456789;
    load_block(pt, key);
    bus_write(reg_ctrl, (32'd15 << ctrl_rnd_lsb) | 32'(cmd_start));
    bus_read(reg_status, q);
    check_val("busy status", 36'd1, 36'(q));
    bus_read(reg_pt_lo, q); // puts the second start on the cycle of next_round.
    check_val("pt readback", 36'(pt[17:0]), 36'(q));
    bus_write(reg_ctrl, (32'd15 << ctrl_rnd_lsb) | 32'(cmd_start));
    wait_done();
    read_result(ct);
    check_val("start while busy", cipher_ref(pt, key, 15), ct);
    bus_write(reg_ctrl, 32'(cmd_clear));
    bus_read(reg_status, q);
    check_val("clear status", 36'd0, 36'(q));
    read_result(ct);
    check_val("clear result", 36'd0, ct);

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
